// ==== tb.f ====
+incdir+hdl
hdl/mbus_pkg.sv
hdl/mbus_decode.sv
hdl/rom_mapper.sv
hdl/mbus_ram.sv
hdl/z80_ctrl_regs.sv
hdl/mbus_ctrl.sv
hdl/genesis_mbus.sv
tb/tb_genesis_mbus.sv

// ==== tb/tb_genesis_mbus.sv ====
/*
 * Testbench for the main-bus top level: clock and reset,
 * ROM model, memory shadows, reference function and checks
 */
`timescale 1ns/10ps
`include "mbus_params.svh"

module tb_genesis_mbus
	import mbus_pkg::*;
();

	localparam int TIMEOUT = 200;

	// Expected result of one read
	typedef struct packed {
		data_t     rdata;
		rom_addr_t rom_addr;
		logic      rom_hit;
	} expect_t;

	logic      MCLK = 1'b0;
	logic      reset;
	logic      as_n;
	mbus_req_t req;
	logic      dtack_n;
	data_t     rdata;
	rom_addr_t rom_size;
	rom_addr_t rom_addr;
	logic      rom_req;
	logic      rom_ack = 1'b0;
	data_t     rom_data = '0;
	logic      z80_busrq_n;
	logic      z80_reset_n;

	integer    seed = 32'ha9c0;

	// Shadow state
	data_t     ram_model [`MBUS_RAM_WORDS];
	data_t     sram_model [`MBUS_RAM_WORDS];
	bank_t     bank_m [8];
	logic      map_en_m = 1'b0;
	logic      busrq_m = 1'b1;
	logic      reset_m = 1'b0;

	mbus_req_t  cur_req;
	logic       pending = 1'b0;
	expect_t    expected;
	int         reads_checked = 0;
	word_addr_t addr_list [16];
	logic       rom_busy = 1'b0;
	int         rom_delay = 0;

	genesis_mbus genesis_mbus_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.as_n        (as_n),
		.req         (req),
		.dtack_n     (dtack_n),
		.rdata       (rdata),
		.rom_size    (rom_size),
		.rom_addr    (rom_addr),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.rom_data    (rom_data),
		.z80_busrq_n (z80_busrq_n),
		.z80_reset_n (z80_reset_n)
	);

	always #10 MCLK = ~MCLK;

	// --------------------
	// Helpers
	// --------------------
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp_v);
		if (got !== exp_v)
			stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp_v));
	endtask

	task automatic check_rom_addr(input string name, input rom_addr_t got,
		input rom_addr_t exp_v);
		if (got !== exp_v)
			stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp_v));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp_v);
		if (got !== exp_v)
			stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp_v));
	endtask

	// ROM contents
	function automatic data_t rom_word(input rom_addr_t a);
		return a[16:1] ^ 16'hA5C3;
	endfunction

	function automatic region_t classify(input word_addr_t addr);
		logic [23:0] b;
		b = {addr, 1'b0};
		if (b >= 24'hE00000)
			return REG_RAM;
		if (b < 24'hA00000) begin
			if ({1'b0, addr} < rom_size)
				return REG_ROM;
			if (b >= 24'h200000 && b < 24'h380000)
				return REG_SRAM;
			return REG_ROM_EMPTY;
		end
		if (b[23:12] == 12'hA11 && b[7:0] == 8'h00)
			return REG_CTRL;
		return REG_NONE;
	endfunction

	// Reference model of a read
	function automatic expect_t expect_read(input word_addr_t addr);
		expect_t e;
		e.rdata    = 16'hFFFF;
		e.rom_addr = '0;
		e.rom_hit  = 1'b0;
		case (classify(addr))
		REG_RAM:       e.rdata = ram_model[addr[15:1]];
		REG_SRAM:      e.rdata = sram_model[addr[15:1]];
		REG_ROM_EMPTY: e.rdata = 16'h0000;
		REG_ROM: begin
			e.rom_hit = 1'b1;
			if (map_en_m)
				e.rom_addr = {bank_m[addr[21:19]], addr[18:1]};
			else
				e.rom_addr = {1'b0, addr};
			e.rdata = rom_word(e.rom_addr);
		end
		REG_CTRL:
			if (addr[11:8] == 4'h1)
				e.rdata[8] = busrq_m;
			else if (addr[11:8] == 4'h2)
				e.rdata[8] = reset_m;
		default: ;
		endcase
		return e;
	endfunction

	// Byte-merged shadow update for a write
	task automatic apply_write(input mbus_req_t w);
		region_t rg;
		rg = classify(w.addr);
		if (rg == REG_RAM) begin
			if (!w.uds_n)
				ram_model[w.addr[15:1]][15:8] = w.wdata[15:8];
			if (!w.lds_n)
				ram_model[w.addr[15:1]][7:0] = w.wdata[7:0];
		end else if (rg == REG_SRAM) begin
			if (!w.uds_n)
				sram_model[w.addr[15:1]][15:8] = w.wdata[15:8];
			if (!w.lds_n)
				sram_model[w.addr[15:1]][7:0] = w.wdata[7:0];
		end else if (rg == REG_CTRL && !w.uds_n) begin
			if (w.addr[11:8] == 4'h1)
				busrq_m = ~w.wdata[8];
			if (w.addr[11:8] == 4'h2)
				reset_m = w.wdata[8];
		end
		if (w.addr[23:4] == 20'hA130F && w.addr[3:1] != 3'd0) begin
			bank_m[w.addr[3:1]] = w.wdata[5:0];
			map_en_m = 1'b1;
		end
	endtask

	// One access, from AS low until DTACK is released
	task automatic bus_access(input word_addr_t addr, input data_t wdata, input logic rnw,
		input logic uds_n, input logic lds_n);
		mbus_req_t r;
		int        wait_cnt;
		r.addr  = addr;
		r.wdata = wdata;
		r.rnw   = rnw;
		r.uds_n = uds_n;
		r.lds_n = lds_n;
		@(posedge MCLK);
		req     <= r;
		as_n    <= 1'b0;
		cur_req = r;
		pending = 1'b1;
		wait_cnt = 0;
		do begin
			@(negedge MCLK);
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				stop_with_failure($sformatf("no dtack for address %h", addr));
		end while (dtack_n);
		@(posedge MCLK);
		as_n <= 1'b1;
		wait_cnt = 0;
		do begin
			@(negedge MCLK);
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				stop_with_failure("dtack_n stayed low after as_n went high");
		end while (!dtack_n);
	endtask

	// --------------------
	// ROM model
	// --------------------
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack  <= 1'b0;
			rom_busy <= 1'b0;
		end else if (rom_busy) begin
			if (rom_delay == 0) begin
				rom_ack  <= rom_req;
				rom_data <= rom_word(rom_addr);
				rom_busy <= 1'b0;
			end else begin
				rom_delay <= rom_delay - 1;
			end
		end else if (rom_req != rom_ack) begin
			rom_busy  <= 1'b1;
			rom_delay <= $unsigned($random(seed)) % 6;
		end
	end

	// Compare each completed access once
	always @(negedge MCLK) begin
		if (pending && !dtack_n) begin
			pending = 1'b0;
			if (cur_req.rnw) begin
				expected = expect_read(cur_req.addr);
				check_data("rdata", rdata, expected.rdata);
				if (expected.rom_hit)
					check_rom_addr("rom_addr", rom_addr, expected.rom_addr);
				reads_checked++;
			end else begin
				apply_write(cur_req);
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	initial begin
		int         i;
		int         r;
		word_addr_t a;
		for (i = 0; i < 8; i++)
			bank_m[i] = bank_t'(i);
		reset     = 1'b1;
		as_n      = 1'b1;
		req       = '0;
		req.rnw   = 1'b1;
		req.uds_n = 1'b1;
		req.lds_n = 1'b1;
		// 4 MB cartridge, counted in words
		rom_size  = 24'h200000;
		repeat (8) @(posedge MCLK);
		reset <= 1'b0;
		@(negedge MCLK);

		check_flag("dtack_n", dtack_n, 1'b1);
		check_flag("rom_req", rom_req, 1'b0);
		check_flag("z80_busrq_n", z80_busrq_n, 1'b1);
		check_flag("z80_reset_n", z80_reset_n, 1'b0);

		// Work RAM, full words first so no byte stays unknown
		for (i = 0; i < 16; i++) begin
			r = $random(seed);
			addr_list[i] = {3'b111, r[19:0]};
			bus_access(addr_list[i], r[31:16], 1'b0, 1'b0, 1'b0);
		end
		for (i = 0; i < 32; i++) begin
			r = $random(seed);
			a = addr_list[$unsigned($random(seed)) % 16];
			bus_access(a, r[31:16], 1'b0, r[0], r[1] & ~r[0]);
		end
		for (i = 0; i < 16; i++)
			bus_access(addr_list[i], '0, 1'b1, 1'b0, 1'b0);

		// ROM reads with the mapper still off
		for (i = 0; i < 20; i++) begin
			r = $random(seed);
			bus_access({2'b00, r[20:0]}, '0, 1'b1, 1'b0, 1'b0);
		end

		// Mapper registers 1-7, then reads across all eight slots
		for (i = 1; i < 8; i++) begin
			r = $random(seed);
			bus_access({20'hA130F, i[2:0]}, r[15:0], 1'b0, 1'b1, 1'b0);
		end
		for (i = 0; i < 24; i++) begin
			r = $random(seed);
			bus_access({2'b00, r[20:0]}, '0, 1'b1, 1'b0, 1'b0);
		end

		// 2 MB cartridge leaves the SRAM window open
		@(posedge MCLK);
		rom_size <= 24'h100000;
		for (i = 0; i < 8; i++) begin
			r = $random(seed);
			addr_list[i] = {4'b0010, r[18:0]};
			bus_access(addr_list[i], r[31:16], 1'b0, 1'b0, 1'b0);
		end
		for (i = 0; i < 8; i++)
			bus_access(addr_list[i], '0, 1'b1, 1'b0, 1'b0);
		bus_access(23'h1C0000, '0, 1'b1, 1'b0, 1'b0);
		bus_access(23'h500000, '0, 1'b1, 1'b0, 1'b0);

		// Z80 control at A11100 and A11200
		// Reset flag still low from reset
		bus_access(23'h508900, '0, 1'b1, 1'b0, 1'b0);
		bus_access(23'h508880, 16'h0100, 1'b0, 1'b0, 1'b0);
		check_flag("z80_busrq_n", z80_busrq_n, busrq_m);
		bus_access(23'h508880, '0, 1'b1, 1'b0, 1'b0);
		bus_access(23'h508900, 16'h0100, 1'b0, 1'b0, 1'b0);
		check_flag("z80_reset_n", z80_reset_n, reset_m);
		bus_access(23'h508900, '0, 1'b1, 1'b0, 1'b0);
		// Lower byte alone leaves the flag as it is
		bus_access(23'h508900, 16'h0000, 1'b0, 1'b1, 1'b0);
		check_flag("z80_reset_n", z80_reset_n, reset_m);
		bus_access(23'h508880, 16'h0000, 1'b0, 1'b0, 1'b1);
		check_flag("z80_busrq_n", z80_busrq_n, busrq_m);
		bus_access(23'h508880, '0, 1'b1, 1'b0, 1'b0);
		bus_access(23'h508900, '0, 1'b1, 1'b0, 1'b0);

		$display("%0d reads compared", reads_checked);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== hdl/genesis_mbus.sv ====
/*
 * Main-bus top level with decoder, mapper,
 * work RAM, SRAM and Z80 control registers
 */
`timescale 1ns/10ps

module genesis_mbus
	import mbus_pkg::*;
(
	input  logic      MCLK,
	input  logic      reset,
	input  logic      as_n,
	input  mbus_req_t req,
	output logic      dtack_n,
	output data_t     rdata,
	input  rom_addr_t rom_size,
	output rom_addr_t rom_addr,
	output logic      rom_req,
	input  logic      rom_ack,
	input  data_t     rom_data,
	output logic      z80_busrq_n,
	output logic      z80_reset_n
);

	mbus_req_t       bus;
	region_t         region;
	ram_port_t [1:0] ram_port;
	logic            ctrl_sel;
	data_t           ram_q;
	data_t           sram_q;
	data_t           ctrl_q;

	// --------------------
	// Control
	// --------------------

	// RAM selects are folded into ram_port write enables
	mbus_ctrl mbus_ctrl_i (
		.MCLK     (MCLK),
		.reset    (reset),
		.as_n     (as_n),
		.req      (req),
		.dtack_n  (dtack_n),
		.rdata    (rdata),
		.bus      (bus),
		.region   (region),
		.rom_req  (rom_req),
		.rom_ack  (rom_ack),
		.rom_data (rom_data),
		.ram_port (ram_port),
		.ram_sel  (),
		.sram_sel (),
		.ctrl_sel (ctrl_sel),
		.ram_q    (ram_q),
		.sram_q   (sram_q),
		.ctrl_q   (ctrl_q)
	);

	mbus_decode mbus_decode_i (
		.addr     (bus.addr),
		.rom_size (rom_size),
		.region   (region)
	);

	// --------------------
	// Datapath
	// --------------------
	rom_mapper rom_mapper_i (
		.MCLK     (MCLK),
		.reset    (reset),
		.bus      (bus),
		.rom_addr (rom_addr)
	);

	mbus_ram work_ram_i (
		.MCLK (MCLK),
		.port (ram_port[0]),
		.q    (ram_q)
	);

	mbus_ram sram_i (
		.MCLK (MCLK),
		.port (ram_port[1]),
		.q    (sram_q)
	);

	z80_ctrl_regs z80_ctrl_regs_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.sel         (ctrl_sel),
		.bus         (bus),
		.q           (ctrl_q),
		.z80_busrq_n (z80_busrq_n),
		.z80_reset_n (z80_reset_n)
	);

endmodule

// ==== hdl/mbus_ctrl.sv ====
/*
 * Main-bus state machine, request latch,
 * read data capture and DTACK generation
 */
`timescale 1ns/10ps
`include "mbus_params.svh"

module mbus_ctrl
	import mbus_pkg::*;
(
	input  logic            MCLK,
	input  logic            reset,
	input  logic            as_n,
	input  mbus_req_t       req,
	output logic            dtack_n,
	output data_t           rdata,
	output mbus_req_t       bus,
	input  region_t         region,
	output logic            rom_req,
	input  logic            rom_ack,
	input  data_t           rom_data,
	output ram_port_t [1:0] ram_port,
	output logic            ram_sel,
	output logic            sram_sel,
	output logic            ctrl_sel,
	input  data_t           ram_q,
	input  data_t           sram_q,
	input  data_t           ctrl_q
);

	mbus_state_t state;
	word_addr_t  bus_addr;
	data_t       bus_wdata;
	logic        bus_rnw;
	logic        bus_uds_n;
	logic        bus_lds_n;
	logic        accept;

	// New access only once the previous DTACK has been released
	assign accept = (state == MB_IDLE) && !as_n && dtack_n;

	assign bus = '{addr: bus_addr, wdata: bus_wdata, rnw: bus_rnw,
		uds_n: bus_uds_n, lds_n: bus_lds_n};

	// --------------------
	// Bus FSM
	// --------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state     <= MB_IDLE;
			dtack_n   <= 1'b1;
			rom_req   <= 1'b0;
			ram_sel   <= 1'b0;
			sram_sel  <= 1'b0;
			ctrl_sel  <= 1'b0;
			bus_rnw   <= 1'b1;
			bus_uds_n <= 1'b1;
			bus_lds_n <= 1'b1;
		end else begin
			if (as_n)
				dtack_n <= 1'b1;

			case (state)
			MB_IDLE: begin
				ram_sel   <= 1'b0;
				sram_sel  <= 1'b0;
				ctrl_sel  <= 1'b0;
				// Strobes dropped so no write repeats while idle
				bus_rnw   <= 1'b1;
				bus_uds_n <= 1'b1;
				bus_lds_n <= 1'b1;
				if (accept) begin
					bus_rnw   <= req.rnw;
					bus_uds_n <= req.uds_n;
					bus_lds_n <= req.lds_n;
					state     <= MB_SELECT;
				end
			end
			MB_SELECT: begin
				state <= MB_FINISH;
				case (region)
				REG_ROM: begin
					rom_req <= ~rom_req;
					state   <= MB_ROM_READ;
				end
				REG_SRAM: begin
					sram_sel <= 1'b1;
					state    <= MB_SRAM_READ;
				end
				REG_RAM: begin
					ram_sel <= 1'b1;
					state   <= MB_RAM_READ;
				end
				REG_CTRL:
					ctrl_sel <= 1'b1;
				default: ;
				endcase
			end
			MB_RAM_READ,
			MB_SRAM_READ:
				state <= MB_FINISH;
			MB_ROM_READ:
				if (rom_ack == rom_req)
					state <= MB_FINISH;
			MB_FINISH: begin
				dtack_n <= 1'b0;
				state   <= MB_IDLE;
			end
			default:
				state <= MB_IDLE;
			endcase
		end
	end

	// --------------------
	// Address and data
	// --------------------
	always_ff @(posedge MCLK) begin
		if (accept) begin
			bus_addr  <= req.addr;
			bus_wdata <= req.wdata;
		end
	end

	// rdata settles before DTACK falls and holds until the next capture
	always_ff @(posedge MCLK) begin
		case (state)
		MB_SELECT:
			case (region)
			REG_CTRL:      rdata <= ctrl_q;
			REG_ROM_EMPTY: rdata <= `ROM_OUT_OF_RANGE_DATA;
			REG_NONE:      rdata <= `NO_DEVICE_DATA;
			default: ;
			endcase
		MB_RAM_READ:
			rdata <= ram_q;
		MB_SRAM_READ:
			rdata <= sram_q;
		MB_ROM_READ:
			if (rom_ack == rom_req)
				rdata <= rom_data;
		default: ;
		endcase
	end

	// Index 0 feeds work RAM, index 1 the SRAM
	always_comb begin
		ram_port[0].addr  = bus_addr[15:1];
		ram_port[0].wdata = bus_wdata;
		ram_port[0].we_u  = ram_sel & ~bus_rnw & ~bus_uds_n;
		ram_port[0].we_l  = ram_sel & ~bus_rnw & ~bus_lds_n;
		ram_port[1].addr  = bus_addr[15:1];
		ram_port[1].wdata = bus_wdata;
		ram_port[1].we_u  = sram_sel & ~bus_rnw & ~bus_uds_n;
		ram_port[1].we_l  = sram_sel & ~bus_rnw & ~bus_lds_n;
	end

endmodule

// ==== hdl/z80_ctrl_regs.sv ====
/*
 * Z80 bus request and reset registers, with readback
 */
`timescale 1ns/10ps
`include "mbus_params.svh"

module z80_ctrl_regs
	import mbus_pkg::*;
(
	input  logic      MCLK,
	input  logic      reset,
	input  logic      sel,
	input  mbus_req_t bus,
	output data_t     q,
	output logic      z80_busrq_n,
	output logic      z80_reset_n
);

	localparam data_t NO_DATA = `NO_DEVICE_DATA;

	logic busrq_hit;
	logic reset_hit;
	logic flag;

	// A11100 and A11200
	assign busrq_hit = bus.addr[11:8] == 4'h1;
	assign reset_hit = bus.addr[11:8] == 4'h2;

	// Only the upper byte carries the control bit
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (sel && !bus.rnw && !bus.uds_n) begin
			if (busrq_hit)
				z80_busrq_n <= ~bus.wdata[8];
			if (reset_hit)
				z80_reset_n <= bus.wdata[8];
		end
	end

	assign flag = busrq_hit ? z80_busrq_n : reset_hit ? z80_reset_n : NO_DATA[8];
	assign q    = {NO_DATA[15:9], flag, NO_DATA[7:0]};

endmodule

// ==== hdl/mbus_ram.sv ====
/*
 * 32K x 16 synchronous RAM with byte write enables
 */
`timescale 1ns/10ps
`include "mbus_params.svh"

module mbus_ram
	import mbus_pkg::*;
(
	input  logic      MCLK,
	input  ram_port_t port,
	output data_t     q
);

	data_t mem [`MBUS_RAM_WORDS];

	// Lanes written independently, read is registered
	always_ff @(posedge MCLK) begin
		if (port.we_u)
			mem[port.addr][15:8] <= port.wdata[15:8];
		if (port.we_l)
			mem[port.addr][7:0] <= port.wdata[7:0];
		q <= mem[port.addr];
	end

endmodule

// ==== hdl/rom_mapper.sv ====
/*
 * SSF2 bank mapper with ROM address translation
 */
`timescale 1ns/10ps
`include "mbus_params.svh"

module rom_mapper
	import mbus_pkg::*;
(
	input  logic      MCLK,
	input  logic      reset,
	input  mbus_req_t bus,
	output rom_addr_t rom_addr
);

	bank_t banks [8];
	logic  map_en;
	logic  bank_wr;

	// Register 0 is fixed, so index zero does not write
	assign bank_wr = !bus.rnw && (bus.addr[23:4] == `MBUS_MAPPER_BASE)
		&& (bus.addr[3:1] != 3'd0);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				banks[i] <= bank_t'(i);
			map_en <= 1'b0;
		end else if (bank_wr) begin
			banks[bus.addr[3:1]] <= bus.wdata[5:0];
			map_en <= 1'b1;
		end
	end

	// --------------------
	// Translation
	// --------------------

	// Each 512 KB slot picks its bank by bits 21:19
	always_comb begin
		if (map_en)
			rom_addr = {banks[bus.addr[21:19]], bus.addr[18:1]};
		else
			rom_addr = {1'b0, bus.addr};
	end

endmodule

// ==== hdl/mbus_decode.sv ====
/*
 * Address decoder for the main bus
 */
`timescale 1ns/10ps
`include "mbus_params.svh"

module mbus_decode
	import mbus_pkg::*;
(
	input  word_addr_t addr,
	input  rom_addr_t  rom_size,
	output region_t    region
);

	logic [23:0] byte_addr;
	logic        in_rom_space;
	logic        in_sram_window;
	logic        in_ctrl_page;

	assign byte_addr = {addr, 1'b0};

	// Cartridge space is everything below A00000
	assign in_rom_space = addr[23:20] < `MBUS_ROM_LIMIT;

	assign in_sram_window = (byte_addr >= `MBUS_SRAM_LO) && (byte_addr <= `MBUS_SRAM_HI);

	// Only A11x00 hits, the low byte must be zero
	assign in_ctrl_page = (addr[23:12] == `MBUS_CTRL_PAGE) && (addr[7:1] == 7'd0);

	always_comb begin
		region = REG_NONE;
		if (&addr[23:21]) begin
			// 64 KB work RAM, mirrored over E00000-FFFFFF
			region = REG_RAM;
		end else if (in_rom_space) begin
			if ({1'b0, addr} < rom_size)
				region = REG_ROM;
			else if (in_sram_window)
				region = REG_SRAM;
			else
				region = REG_ROM_EMPTY;
		end else if (in_ctrl_page) begin
			region = REG_CTRL;
		end
	end

endmodule

// ==== hdl/mbus_pkg.sv ====
/*
 * Main-bus vector types, request and RAM port structs,
 * region and bus state enums
 */
package mbus_pkg;

	// 68000 word address, A0 is carried by the strobes
	typedef logic [23:1] word_addr_t;
	typedef logic [24:1] rom_addr_t;
	typedef logic [15:0] data_t;
	typedef logic [14:0] ram_addr_t;
	typedef logic [5:0]  bank_t;

	// One access as seen by the bus master
	typedef struct packed {
		word_addr_t addr;
		data_t      wdata;
		logic       rnw;
		logic       uds_n;
		logic       lds_n;
	} mbus_req_t;

	// Byte-lane RAM port
	typedef struct packed {
		ram_addr_t addr;
		data_t     wdata;
		logic      we_u;
		logic      we_l;
	} ram_port_t;

	typedef enum logic [2:0] {
		REG_NONE,
		REG_ROM,
		REG_ROM_EMPTY,
		REG_SRAM,
		REG_RAM,
		REG_CTRL
	} region_t;

	typedef enum logic [2:0] {
		MB_IDLE,
		MB_SELECT,
		MB_RAM_READ,
		MB_SRAM_READ,
		MB_ROM_READ,
		MB_FINISH
	} mbus_state_t;

endpackage

// ==== hdl/mbus_params.svh ====
/*
 * Main-bus address windows, work RAM depth
 * and the fixed values returned for empty space
 */
`ifndef MBUS_PARAMS_SVH
`define MBUS_PARAMS_SVH

// --------------------
// Address windows
// --------------------

// Upper address nibble where the cartridge window ends
`define MBUS_ROM_LIMIT 4'hA

// Backup SRAM, byte addresses
`define MBUS_SRAM_LO 24'h200000
`define MBUS_SRAM_HI 24'h37FFFF

// Z80 control page, matched on bits 23:12
`define MBUS_CTRL_PAGE 12'hA11

// Bank registers at A130F2..A130FE, matched on bits 23:4
`define MBUS_MAPPER_BASE 20'hA130F

// --------------------
// Memories and fixed data
// --------------------

`define MBUS_RAM_WORDS 32768

// Floating bus
`define NO_DEVICE_DATA 16'hFFFF
`define ROM_OUT_OF_RANGE_DATA 16'h0000

`endif
